/* rtl/muldiv_params.svh */
/*
 * Multiply/divide cluster constants
 * Data word, instruction tag and leading-zero count widths
 */
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// Data word width
`define XLEN 32

// Instruction tag width, eight tags in flight at most
`define ID_W 3

// Leading-zero count width, enough for 0..31
`define CLZ_W 5

`endif

/* rtl/muldiv_pkg.sv */
/*
 * Multiply/divide cluster types
 * Word, tag, count and operation encoding shared by all units
 */
`include "muldiv_params.svh"

package muldiv_pkg;

    typedef logic [`XLEN-1:0]  xlen_t;
    typedef logic [`ID_W-1:0]  id_t;
    typedef logic [`CLZ_W-1:0] clz_t;

    // Bit 2 picks the divider
    // Divide: bit 1 remainder, bit 0 unsigned
    // Multiply: low word, then the three high-word variants
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } muldiv_op_t;

endpackage

/* rtl/clz.sv */
/*
 * Leading-zero counter
 * Priority encoder over one data word, zero input reads as 31
 */
`timescale 1ns/1ps
`include "muldiv_params.svh"

module clz import muldiv_pkg::*; (
    input  xlen_t value,
    output clz_t  count
);

    ////////////////////////////////////////////////////////////
    // Priority encode
    // Scan upward so the highest set bit wins
    always_comb begin
        // Zero input falls through to 31, same as value 1
        count = clz_t'(`XLEN - 1);
        for (int i = 0; i < `XLEN; i++) begin
            if (value[i]) begin
                count = clz_t'(`XLEN - 1 - i);
            end
        end
    end

    // Caller tells zero from one by bit 0

endmodule

/* rtl/div_core.sv */
/*
 * Unsigned iterative divider core
 * Restoring shift-subtract, skips the iterations the leading zeros rule out
 */
`timescale 1ns/1ps
`include "muldiv_params.svh"

module div_core import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  xlen_t dividend,
    input  xlen_t divisor,
    input  clz_t  dividend_clz,
    input  clz_t  divisor_clz,
    input  logic  divisor_is_zero,
    output logic  done,
    output xlen_t quotient,
    output xlen_t remainder
);

    logic [`CLZ_W:0]     clz_diff;
    logic [`CLZ_W:0]     iters;
    logic [`CLZ_W:0]     pre_shift;
    logic [2*`XLEN-1:0]  start_value;
    logic [`XLEN:0]      shifted_rem;
    logic [`XLEN:0]      trial;
    logic [`CLZ_W:0]     count;
    logic                running;
    xlen_t               rem_r;
    xlen_t               dq_r;
    xlen_t               divisor_r;

    ////////////////////////////////////////////////////////////
    // Iteration count from the clz difference
    assign clz_diff = {1'b0, divisor_clz} - {1'b0, dividend_clz};
    // Divisor wider than dividend, or zero: no quotient bits
    assign iters = (divisor_is_zero | (divisor_clz < dividend_clz)) ? '0
                 : clz_diff + (`CLZ_W+1)'(1);

    // Skipped iterations only shift, so do them all at once
    // With iters of 0 this leaves the dividend in the remainder half
    assign pre_shift   = (`CLZ_W+1)'(`XLEN) - iters;
    assign start_value = {{`XLEN{1'b0}}, dividend} << pre_shift;

    ////////////////////////////////////////////////////////////
    // One restoring step
    assign shifted_rem = {rem_r, dq_r[`XLEN-1]};
    assign trial       = shifted_rem - {1'b0, divisor_r};

    // Datapath, low half collects quotient bits as dividend bits leave
    always_ff @(posedge clk) begin
        if (start) begin
            {rem_r, dq_r} <= start_value;
            divisor_r     <= divisor;
        end else if (running) begin
            // Borrow means restore
            rem_r <= trial[`XLEN] ? shifted_rem[`XLEN-1:0] : trial[`XLEN-1:0];
            dq_r  <= {dq_r[`XLEN-2:0], ~trial[`XLEN]};
        end
    end

    // Control
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= (start & (iters == '0)) | (running & (count == 1));
            if (start) begin
                running <= (iters != '0);
                count   <= iters;
            end else if (running) begin
                running <= (count != 1);
                count   <= count - (`CLZ_W+1)'(1);
            end
        end
    end

    assign quotient  = dq_r;
    assign remainder = rem_r;

endmodule

/* rtl/div_unit.sv */
/*
 * Divider functional unit
 * Sign handling, one-entry input register, iterative core and result
 * fix-up, result held for the writeback arbiter until acked
 */
`timescale 1ns/1ps

module div_unit import muldiv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  muldiv_op_t issue_op,
    input  xlen_t      issue_rs1,
    input  xlen_t      issue_rs2,
    input  id_t        issue_id,
    input  logic       ack,
    output logic       ready,
    output logic       done,
    output id_t        id,
    output xlen_t      rd
);

    logic  signed_op, neg_dividend, neg_divisor, neg_q, neg_r;
    logic  accept, pop, in_valid, in_progress, core_done, divisor_is_zero, neg_result;
    xlen_t abs_dividend, abs_divisor, quotient, remainder;
    clz_t  dividend_clz, divisor_clz;

    // Input register payload
    xlen_t in_dividend, in_divisor;
    clz_t  in_dividend_clz, in_divisor_clz;
    logic  in_rem_op, in_neg_q, in_neg_r, in_div_zero;
    id_t   in_id;

    // Attributes of the op in the core
    logic  prog_rem_op, prog_neg_q, prog_neg_r, prog_div_zero;
    id_t   prog_id;

    function automatic xlen_t negate_if(input xlen_t value, input logic neg);
        return (value ^ {$bits(xlen_t){neg}}) + xlen_t'(neg);
    endfunction

    ////////////////////////////////////////////////////////////
    // Operand signs and magnitudes
    assign signed_op    = ~issue_op[0];
    assign neg_dividend = signed_op & issue_rs1[$bits(xlen_t)-1];
    assign neg_divisor  = signed_op & issue_rs2[$bits(xlen_t)-1];
    // Quotient sign from the xor, remainder follows the dividend
    assign neg_q = neg_dividend ^ neg_divisor;
    assign neg_r = neg_dividend;

    assign abs_dividend = negate_if(issue_rs1, neg_dividend);
    assign abs_divisor  = negate_if(issue_rs2, neg_divisor);

    clz dividend_clz_inst (.value(abs_dividend), .count(dividend_clz));
    clz divisor_clz_inst  (.value(abs_divisor),  .count(divisor_clz));
    // All-ones count is 0 or 1
    assign divisor_is_zero = (&divisor_clz) & ~abs_divisor[0];

    ////////////////////////////////////////////////////////////
    // Input register and in-progress tracking
    assign ready  = ~in_valid | ~in_progress;
    assign accept = issue_valid & issue_op[2] & ready;
    assign pop    = in_valid & (~in_progress | ack);

    always_ff @(posedge clk) begin
        if (accept) begin
            in_dividend     <= abs_dividend;
            in_divisor      <= abs_divisor;
            in_dividend_clz <= dividend_clz;
            in_divisor_clz  <= divisor_clz;
            in_rem_op       <= issue_op[1];
            in_neg_q        <= neg_q;
            in_neg_r        <= neg_r;
            in_div_zero     <= divisor_is_zero;
            in_id           <= issue_id;
        end
        if (pop) begin
            prog_rem_op   <= in_rem_op;
            prog_neg_q    <= in_neg_q;
            prog_neg_r    <= in_neg_r;
            prog_div_zero <= in_div_zero;
            prog_id       <= in_id;
        end
    end

    // Pop wins over ack, done wins over ack
    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid    <= 1'b0;
            in_progress <= 1'b0;
            done        <= 1'b0;
        end else begin
            in_valid    <= accept | (in_valid & ~pop);
            in_progress <= pop | (in_progress & ~ack);
            done        <= core_done | (done & ~ack);
        end
    end

    div_core core_inst (
        .clk             (clk),
        .rst             (rst),
        .start           (pop),
        .dividend        (in_dividend),
        .divisor         (in_divisor),
        .dividend_clz    (in_dividend_clz),
        .divisor_clz     (in_divisor_clz),
        .divisor_is_zero (in_div_zero),
        .done            (core_done),
        .quotient        (quotient),
        .remainder       (remainder)
    );

    ////////////////////////////////////////////////////////////
    // Result fix-up
    // Divide by zero: all-ones quotient, never negated
    assign neg_result = prog_rem_op ? prog_neg_r : (prog_neg_q & ~prog_div_zero);
    assign rd = negate_if(prog_rem_op ? remainder : (quotient | {$bits(xlen_t){prog_div_zero}}),
                          neg_result);
    assign id = prog_id;

endmodule

/* rtl/mul_unit.sv */
/*
 * Multiplier functional unit
 * Two-stage signed/unsigned 33x33 multiply, result held until acked
 */
`timescale 1ns/1ps
`include "muldiv_params.svh"

module mul_unit import muldiv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  muldiv_op_t issue_op,
    input  xlen_t      issue_rs1,
    input  xlen_t      issue_rs2,
    input  id_t        issue_id,
    input  logic       ack,
    output logic       ready,
    output logic       done,
    output id_t        id,
    output xlen_t      rd
);

    logic                      accept, s1_valid, s1_advance, s1_high, s2_high;
    logic                      a_signed, b_signed;
    logic signed [`XLEN:0]     s1_a, s1_b;
    logic signed [2*`XLEN+1:0] product;
    id_t                       s1_id;

    ////////////////////////////////////////////////////////////
    // Stage 1, operand extension
    // rs1 signed for MULH and MULHSU, rs2 only for MULH
    assign a_signed = (issue_op == OP_MULH) | (issue_op == OP_MULHSU);
    assign b_signed = (issue_op == OP_MULH);

    // Stage 2 frees up when empty or being acked
    assign s1_advance = ~done | ack;
    assign ready      = ~s1_valid | s1_advance;
    assign accept     = issue_valid & ~issue_op[2] & ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_a    <= {a_signed & issue_rs1[`XLEN-1], issue_rs1};
            s1_b    <= {b_signed & issue_rs2[`XLEN-1], issue_rs2};
            s1_high <= (issue_op != OP_MUL);
            s1_id   <= issue_id;
        end
        // Stage 2, product
        if (s1_valid & s1_advance) begin
            product <= (2*`XLEN+2)'(s1_a) * (2*`XLEN+2)'(s1_b);
            s2_high <= s1_high;
            id      <= s1_id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= accept | (s1_valid & ~s1_advance);
            done     <= (s1_valid & s1_advance) | (done & ~ack);
        end
    end

    assign rd = s2_high ? product[2*`XLEN-1:`XLEN] : product[`XLEN-1:0];

endmodule

/* rtl/wb_arbiter.sv */
/*
 * Writeback arbiter
 * Round-robin grant of the shared writeback port, one unit per cycle
 */
`timescale 1ns/1ps

module wb_arbiter import muldiv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  div_done,
    input  id_t   div_id,
    input  xlen_t div_rd,
    input  logic  mul_done,
    input  id_t   mul_id,
    input  xlen_t mul_rd,
    output logic  div_ack,
    output logic  mul_ack,
    output logic  wb_valid,
    output id_t   wb_id,
    output xlen_t wb_rd
);

    // Set when the divider had the last grant
    logic last_div;

    ////////////////////////////////////////////////////////////
    // Grant
    // Divider yields only on a tie right after its own grant
    assign div_ack = div_done & (~mul_done | ~last_div);
    assign mul_ack = mul_done & ~div_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_div <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= div_ack | mul_ack;
            if (div_ack | mul_ack) begin
                last_div <= div_ack;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback payload
    always_ff @(posedge clk) begin
        if (div_ack) begin
            wb_id <= div_id;
            wb_rd <= div_rd;
        end else if (mul_ack) begin
            wb_id <= mul_id;
            wb_rd <= mul_rd;
        end
    end

endmodule

/* rtl/muldiv_top.sv */
/*
 * Multiply/divide execution cluster
 * Shared issue port, divider and multiplier units, arbitrated writeback
 */
`timescale 1ns/1ps

module muldiv_top import muldiv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  muldiv_op_t issue_op,
    input  xlen_t      issue_rs1,
    input  xlen_t      issue_rs2,
    input  id_t        issue_id,
    output logic       div_ready,
    output logic       mul_ready,
    output logic       wb_valid,
    output id_t        wb_id,
    output xlen_t      wb_rd
);

    // Unit to arbiter
    logic  div_done, div_ack, mul_done, mul_ack;
    id_t   div_id, mul_id;
    xlen_t div_rd, mul_rd;

    ////////////////////////////////////////////////////////////
    // Functional units, each filters on op bit 2
    div_unit div_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .ack         (div_ack),
        .ready       (div_ready),
        .done        (div_done),
        .id          (div_id),
        .rd          (div_rd)
    );

    mul_unit mul_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .ack         (mul_ack),
        .ready       (mul_ready),
        .done        (mul_done),
        .id          (mul_id),
        .rd          (mul_rd)
    );

    // Writeback
    wb_arbiter arb_inst (
        .clk      (clk),
        .rst      (rst),
        .div_done (div_done),
        .div_id   (div_id),
        .div_rd   (div_rd),
        .mul_done (mul_done),
        .mul_id   (mul_id),
        .mul_rd   (mul_rd),
        .div_ack  (div_ack),
        .mul_ack  (mul_ack),
        .wb_valid (wb_valid),
        .wb_id    (wb_id),
        .wb_rd    (wb_rd)
    );

endmodule

/* tb/muldiv_tb.sv */
/*
 * Multiply/divide cluster testbench
 * Table-driven and random ops, RV32M reference model, id scoreboard
 */
`timescale 1ns/1ps

module muldiv_tb import muldiv_pkg::*; ();

    localparam int NUM_IDS    = 1 << $bits(id_t);
    localparam int WAIT_LIMIT = 200;
    localparam int DRAIN_LIMIT = 1000;

    logic       clk, rst, issue_valid;
    muldiv_op_t issue_op;
    xlen_t      issue_rs1, issue_rs2;
    id_t        issue_id;
    logic       div_ready, mul_ready, wb_valid;
    id_t        wb_id;
    xlen_t      wb_rd;

    // Scoreboard, indexed by id
    bit    busy     [NUM_IDS];
    bit    exp_div  [NUM_IDS];
    xlen_t exp_rd   [NUM_IDS];
    string exp_name [NUM_IDS];
    // Each unit retires in its own issue order
    id_t   div_order[$];
    id_t   mul_order[$];
    id_t   next_id;

    // Stimulus table
    string      tbl_name[$];
    muldiv_op_t tbl_op[$];
    xlen_t      tbl_rs1[$];
    xlen_t      tbl_rs2[$];

    muldiv_top uut (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_id    (issue_id),
        .div_ready   (div_ready),
        .mul_ready   (mul_ready),
        .wb_valid    (wb_valid),
        .wb_id       (wb_id),
        .wb_rd       (wb_rd)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model and helpers
    // RV32M results straight from the ISA rules
    function automatic xlen_t ref_result(input muldiv_op_t op, input xlen_t a, input xlen_t b);
        logic [63:0] ea, eb, prod;
        int          sa, sb;
        sa = a;
        sb = b;
        // Sign extension only where the op treats the operand as signed
        ea = {{32{a[31] & ((op == OP_MULH) | (op == OP_MULHSU))}}, a};
        eb = {{32{b[31] & (op == OP_MULH)}}, b};
        prod = ea * eb;
        case (op)
            OP_MUL:  return prod[31:0];
            OP_DIV: begin
                if (b == 0) return '1;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;
                return sa / sb;
            end
            OP_DIVU: return (b == 0) ? '1 : a / b;
            OP_REM: begin
                if (b == 0) return a;
                if (a == 32'h8000_0000 && b == 32'hffff_ffff) return '0;
                return sa % sb;
            end
            OP_REMU: return (b == 0) ? a : a % b;
            default: return prod[63:32];
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] seed);
        logic [31:0] s;
        s = seed;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rd(input string name, input xlen_t expected, input xlen_t actual);
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            fail_now("result mismatch on the writeback port");
        end
    endtask

    task automatic check_id(input string name, input id_t expected, input id_t actual);
        if (expected !== actual) begin
            $display("FAILED %s expected id %0d actual id %0d", name, expected, actual);
            fail_now("writeback id out of unit order");
        end
    endtask

    function automatic bit any_busy();
        for (int i = 0; i < NUM_IDS; i++) begin
            if (busy[i]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic add_entry(input string name, input muldiv_op_t op, input xlen_t a,
                             input xlen_t b);
        tbl_name.push_back(name);
        tbl_op.push_back(op);
        tbl_rs1.push_back(a);
        tbl_rs2.push_back(b);
    endtask

    ////////////////////////////////////////////////////////////
    // Issue, called on a falling edge, returns one falling edge later
    // issue_valid stays high when the next op goes out right away
    task automatic send_op(input string name, input muldiv_op_t op, input xlen_t a,
                           input xlen_t b);
        int   waited;
        logic unit_ready;
        waited = 0;
        unit_ready = op[2] ? div_ready : mul_ready;
        while (unit_ready !== 1'b1 || busy[next_id]) begin
            issue_valid = 1'b0;
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_now($sformatf("timeout waiting to issue %s", name));
            end
            unit_ready = op[2] ? div_ready : mul_ready;
        end
        busy[next_id]     = 1'b1;
        exp_div[next_id]  = op[2];
        exp_rd[next_id]   = ref_result(op, a, b);
        exp_name[next_id] = name;
        if (op[2]) begin
            div_order.push_back(next_id);
        end else begin
            mul_order.push_back(next_id);
        end
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rs1   = a;
        issue_rs2   = b;
        issue_id    = next_id;
        next_id     = next_id + id_t'(1);
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        issue_valid = 1'b0;
        while (any_busy()) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                fail_now("timeout waiting for outstanding results to write back");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback monitor
    // Falling edge, registered outputs are settled
    always @(negedge clk) begin
        if (!rst && wb_valid === 1'b1) begin
            if (!busy[wb_id]) begin
                fail_now($sformatf("writeback with id %0d that is not in flight", wb_id));
            end
            if (exp_div[wb_id]) begin
                check_id(exp_name[wb_id], div_order[0], wb_id);
                void'(div_order.pop_front());
            end else begin
                check_id(exp_name[wb_id], mul_order[0], wb_id);
                void'(mul_order.pop_front());
            end
            check_rd(exp_name[wb_id], exp_rd[wb_id], wb_rd);
            busy[wb_id] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        logic [31:0] rng;
        muldiv_op_t  r_op;
        xlen_t       r_a, r_b;

        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_op    = OP_MUL;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_id    = '0;
        next_id     = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            busy[i] = 1'b0;
        end

        // Ordinary signed and unsigned divide
        add_entry("div_pos",         OP_DIV,  32'd100,      32'd7);
        add_entry("div_neg_dividend", OP_DIV, -32'sd100,    32'd7);
        add_entry("div_neg_divisor", OP_DIV,  32'd100,      -32'sd7);
        add_entry("div_both_neg",    OP_DIV,  -32'sd100,    -32'sd7);
        add_entry("divu_large",      OP_DIVU, 32'hf000_0000, 32'd3);
        add_entry("rem_neg_dividend", OP_REM, -32'sd100,    32'd7);
        add_entry("rem_neg_divisor", OP_REM,  32'd100,      -32'sd7);
        add_entry("remu_large",      OP_REMU, 32'hffff_ffff, 32'd10);
        // Corner cases
        add_entry("div_by_zero",     OP_DIV,  32'd1234,     32'd0);
        add_entry("divu_by_zero",    OP_DIVU, 32'h8765_4321, 32'd0);
        add_entry("rem_by_zero",     OP_REM,  -32'sd5,      32'd0);
        add_entry("remu_by_zero",    OP_REMU, 32'hdead_beef, 32'd0);
        add_entry("div_overflow",    OP_DIV,  32'h8000_0000, 32'hffff_ffff);
        add_entry("rem_overflow",    OP_REM,  32'h8000_0000, 32'hffff_ffff);
        add_entry("div_small",       OP_DIV,  32'd3,        32'd17);
        add_entry("remu_small",      OP_REMU, 32'd3,        32'hffff_0000);
        add_entry("div_by_one",      OP_DIV,  32'hdead_beef, 32'd1);
        add_entry("divu_by_one",     OP_DIVU, 32'hdead_beef, 32'd1);
        // Multiplies, mixed signs and extremes
        add_entry("mul_mixed",       OP_MUL,  -32'sd3,      32'd7);
        add_entry("mul_max",         OP_MUL,  32'hffff_ffff, 32'hffff_ffff);
        add_entry("mulh_mixed",      OP_MULH, 32'h8000_0000, 32'h7fff_ffff);
        add_entry("mulh_min",        OP_MULH, 32'h8000_0000, 32'h8000_0000);
        add_entry("mulhsu_neg",      OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
        add_entry("mulhu_max",       OP_MULHU, 32'hffff_ffff, 32'hffff_ffff);

        // Reset, then idle outputs until the first issue
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (5) begin
            if (wb_valid !== 1'b0 || div_ready !== 1'b1 || mul_ready !== 1'b1) begin
                fail_now("idle outputs wrong after reset");
            end
            @(negedge clk);
        end

        for (int i = 0; i < tbl_name.size(); i++) begin
            send_op(tbl_name[i], tbl_op[i], tbl_rs1[i], tbl_rs2[i]);
        end

        // Back-to-back divides, second one accepted while the first runs
        wait_drain();
        send_op("b2b_div_first", OP_DIV, 32'h7fff_ffff, 32'd3);
        if (div_ready !== 1'b1) begin
            fail_now("div_ready low with only one divide in flight");
        end
        send_op("b2b_div_second", OP_REMU, 32'h1234_5678, 32'd9);
        issue_valid = 1'b0;

        // Random mix, small divisors now and then
        rng = 32'h4a6d6646;
        for (int i = 0; i < 40; i++) begin
            rng  = xorshift32(rng);
            r_op = muldiv_op_t'(rng[2:0]);
            rng  = xorshift32(rng);
            r_a  = rng;
            rng  = xorshift32(rng);
            r_b  = rng[3] ? (rng >> 24) : rng;
            send_op($sformatf("random_%0d", i), r_op, r_a, r_b);
        end

        wait_drain();
        $display("No errors");
        $finish;
    end

endmodule

/* src.f */
+incdir+rtl
rtl/muldiv_pkg.sv
rtl/clz.sv
rtl/div_core.sv
rtl/div_unit.sv
rtl/mul_unit.sv
rtl/wb_arbiter.sv
rtl/muldiv_top.sv
tb/muldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the multiply/divide cluster testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module muldiv_tb -f src.f -o muldiv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/muldiv_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
